// File: hdl/vcr_pkg.sv
// **********************************************************
// Virtual-channel router package
// Router sizes, port directions, flit formats and the
// XY turn rules shared by the allocator and the crossbar
// **********************************************************
`default_nettype none

package vcr_pkg;

  localparam int NumPorts     = 5;
  localparam int NumVc        = 2;
  localparam int VcIdWidth    = 1;
  localparam int BufDepth     = 4;
  localparam int BufPtrWidth  = 2;
  localparam int CreditWidth  = 3;
  localparam int CoordWidth   = 3;
  localparam int PayloadWidth = 32;

  // Flattened (port, channel) requesters seen by the allocator
  localparam int NumReq      = NumPorts * NumVc;
  localparam int ReqIdxWidth = 4;

  // North is y+1, East is x+1
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Local = 3'd4
  } port_e;

  typedef struct packed {
    logic [CoordWidth-1:0] dst_x;
    logic [CoordWidth-1:0] dst_y;
    logic [VcIdWidth-1:0]  vc_id;
    logic                  last;
  } hdr_t;

  typedef struct packed {
    hdr_t                    hdr;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

  // A flit never goes back where it came from, Local excepted
  function automatic logic is_uturn(port_e in_port, port_e out_port);
    return (in_port == out_port) && (in_port != Local);
  endfunction

  // XY routing finishes X before Y, so N/S never turn to E/W
  function automatic logic is_y_to_x(port_e in_port, port_e out_port);
    return ((in_port == North) || (in_port == South)) &&
           ((out_port == East) || (out_port == West));
  endfunction

endpackage

`default_nettype wire

// File: hdl/vcr_xbar_ctrl_if.sv
// **********************************************************
// Crossbar control bundle
// Allocator grants that steer the switch each cycle
// **********************************************************
`default_nettype none

interface vcr_xbar_ctrl_if;
  import vcr_pkg::*;

  // Channel to pop, per input
  logic [NumPorts-1:0][NumVc-1:0]     read_vc_oh;
  // Input feeding each output
  logic [NumPorts-1:0][NumPorts-1:0]  inport_oh;
  // Downstream channel of each output
  logic [NumPorts-1:0][VcIdWidth-1:0] vc_assign;
  logic [NumPorts-1:0]                last_sel;
  logic [NumPorts-1:0]                fire;

  modport alloc (output read_vc_oh, inport_oh, vc_assign, last_sel, fire);
  modport switch (input read_vc_oh, inport_oh, vc_assign, last_sel, fire);

endinterface

`default_nettype wire

// File: hdl/vcr_input_port.sv
// **********************************************************
// Router input port
// One circular FIFO per virtual channel, head flit outputs
// and a registered credit pulse for every pop
// **********************************************************
`default_nettype none

module vcr_input_port (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   in_valid_i,
  input  vcr_pkg::flit_t                         in_flit_i,
  input  logic [vcr_pkg::NumVc-1:0]              read_vc_oh_i,
  output logic [vcr_pkg::NumVc-1:0]              head_valid_o,
  output vcr_pkg::flit_t [vcr_pkg::NumVc-1:0]    head_flit_o,
  output logic [vcr_pkg::NumVc-1:0]              in_credit_o
);
  import vcr_pkg::*;

  for (genvar v = 0; v < NumVc; v++) begin : gen_vc
    flit_t                  mem_q [BufDepth];
    logic [BufPtrWidth-1:0] wr_ptr_q;
    logic [BufPtrWidth-1:0] rd_ptr_q;
    logic [CreditWidth-1:0] count_q;
    logic                   credit_q;
    logic                   push;
    logic                   pop;

    // Incoming flit picks its FIFO by vc_id
    assign push = in_valid_i && (in_flit_i.hdr.vc_id == VcIdWidth'(v));
    assign pop  = read_vc_oh_i[v];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
        credit_q <= 1'b0;
      end else begin
        if (push) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        if (push && !pop) begin
          count_q <= count_q + 1'b1;
        end else if (pop && !push) begin
          count_q <= count_q - 1'b1;
        end
        // Slot freed upstream one cycle after the read
        credit_q <= pop;
      end
    end

    always_ff @(posedge clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q] <= in_flit_i;
      end
    end

    assign head_valid_o[v] = (count_q != '0);
    assign head_flit_o[v]  = mem_q[rd_ptr_q];
    assign in_credit_o[v]  = credit_q;

    // Upstream must hold a credit before sending
    a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      push |-> (count_q != CreditWidth'(BufDepth)))
      else $error("input FIFO written while full, vc %0d", v);

    a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop |-> (count_q != '0))
      else $error("input FIFO popped while empty, vc %0d", v);
  end

endmodule

`default_nettype wire

// File: hdl/vcr_switch_alloc.sv
// **********************************************************
// Switch allocator
// XY route per head flit, per-output packet lock and
// round-robin choice among the requesting channels
// **********************************************************
`default_nettype none

module vcr_switch_alloc #(
  parameter logic [vcr_pkg::CoordWidth-1:0] RouterX = 3'd2,
  parameter logic [vcr_pkg::CoordWidth-1:0] RouterY = 3'd2
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic [vcr_pkg::NumPorts-1:0][vcr_pkg::NumVc-1:0]       head_valid_i,
  input  vcr_pkg::hdr_t [vcr_pkg::NumPorts-1:0][vcr_pkg::NumVc-1:0] head_hdr_i,
  input  logic [vcr_pkg::NumPorts-1:0][vcr_pkg::NumVc-1:0]       has_credit_i,
  vcr_xbar_ctrl_if.alloc                                         ctrl
);
  import vcr_pkg::*;

  typedef enum logic {IDLE, LOCKED} lock_state_e;

  lock_state_e            state_q   [NumPorts];
  logic [ReqIdxWidth-1:0] owner_q   [NumPorts];
  logic [VcIdWidth-1:0]   lock_vc_q [NumPorts];
  logic [ReqIdxWidth-1:0] rr_ptr_q  [NumPorts];

  // Requester r is input r / NumVc, channel r % NumVc
  logic  [NumReq-1:0] req_valid;
  hdr_t  [NumReq-1:0] req_hdr;
  port_e              req_route [NumReq];

  logic [NumPorts-1:0]    gnt_valid;
  logic [ReqIdxWidth-1:0] gnt_req [NumPorts];
  logic [VcIdWidth-1:0]   gnt_vc  [NumPorts];

  assign req_valid = head_valid_i;
  assign req_hdr   = head_hdr_i;

  function automatic port_e xy_route(hdr_t hdr);
    if (hdr.dst_x > RouterX) return East;
    if (hdr.dst_x < RouterX) return West;
    if (hdr.dst_y > RouterY) return North;
    if (hdr.dst_y < RouterY) return South;
    return Local;
  endfunction

  always_comb begin
    for (int r = 0; r < NumReq; r++) begin
      req_route[r] = xy_route(req_hdr[r]);
    end
  end

  always_comb begin
    logic [NumPorts-1:0] in_busy;
    logic                found;
    int unsigned         r;
    in_busy = '0;
    found   = 1'b0;
    r       = 0;
    for (int o = 0; o < NumPorts; o++) begin
      gnt_valid[o] = 1'b0;
      gnt_req[o]   = '0;
      gnt_vc[o]    = '0;
    end
    // Locked outputs first, their owner must keep moving
    for (int o = 0; o < NumPorts; o++) begin
      if (state_q[o] == LOCKED && req_valid[owner_q[o]] &&
          !in_busy[owner_q[o] / NumVc] && has_credit_i[o][lock_vc_q[o]]) begin
        gnt_valid[o]                = 1'b1;
        gnt_req[o]                  = owner_q[o];
        gnt_vc[o]                   = lock_vc_q[o];
        in_busy[owner_q[o] / NumVc] = 1'b1;
      end
    end
    // Free outputs search from their pointer
    for (int o = 0; o < NumPorts; o++) begin
      if (state_q[o] == IDLE && |has_credit_i[o]) begin
        found = 1'b0;
        for (int k = 0; k < NumReq; k++) begin
          r = rr_ptr_q[o] + k;
          if (r >= NumReq) begin
            r = r - NumReq;
          end
          if (!found && req_valid[r] && req_route[r] == port_e'(o) &&
              !in_busy[r / NumVc]) begin
            found      = 1'b1;
            gnt_req[o] = ReqIdxWidth'(r);
          end
        end
        if (found) begin
          gnt_valid[o]                = 1'b1;
          in_busy[gnt_req[o] / NumVc] = 1'b1;
          // Lowest downstream channel with space
          for (int v = NumVc - 1; v >= 0; v--) begin
            if (has_credit_i[o][v]) begin
              gnt_vc[o] = VcIdWidth'(v);
            end
          end
        end
      end
    end
  end

  always_comb begin
    ctrl.read_vc_oh = '0;
    ctrl.inport_oh  = '0;
    ctrl.vc_assign  = '0;
    ctrl.last_sel   = '0;
    ctrl.fire       = gnt_valid;
    for (int o = 0; o < NumPorts; o++) begin
      if (gnt_valid[o]) begin
        ctrl.inport_oh[o][gnt_req[o] / NumVc]                  = 1'b1;
        ctrl.read_vc_oh[gnt_req[o] / NumVc][gnt_req[o] % NumVc] = 1'b1;
        ctrl.vc_assign[o]                                      = gnt_vc[o];
        ctrl.last_sel[o]                                       = req_hdr[gnt_req[o]].last;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int o = 0; o < NumPorts; o++) begin
        state_q[o]   <= IDLE;
        owner_q[o]   <= '0;
        lock_vc_q[o] <= '0;
        rr_ptr_q[o]  <= '0;
      end
    end else begin
      for (int o = 0; o < NumPorts; o++) begin
        if (gnt_valid[o]) begin
          if (req_hdr[gnt_req[o]].last) begin
            state_q[o] <= IDLE;
          end else begin
            state_q[o]   <= LOCKED;
            owner_q[o]   <= gnt_req[o];
            lock_vc_q[o] <= gnt_vc[o];
          end
          if (state_q[o] == IDLE) begin
            rr_ptr_q[o] <= (gnt_req[o] == ReqIdxWidth'(NumReq - 1)) ? '0 : gnt_req[o] + 1'b1;
          end
        end
      end
    end
  end

  for (genvar i = 0; i < NumPorts; i++) begin : gen_in_chk
    logic [NumPorts-1:0] sel_outs;

    for (genvar o = 0; o < NumPorts; o++) begin : gen_sel
      assign sel_outs[o] = ctrl.inport_oh[o][i];
    end

    // One input feeds at most one output per cycle
    a_inport_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(sel_outs))
      else $error("input %0d granted to more than one output", i);
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_chk
    for (genvar i = 0; i < NumPorts; i++) begin : gen_turn
      a_no_uturn : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ctrl.inport_oh[o][i] |-> !is_uturn(port_e'(i), port_e'(o)))
        else $error("U-turn from input %0d", i);

      a_no_y_to_x : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ctrl.inport_oh[o][i] |-> !is_y_to_x(port_e'(i), port_e'(o)))
        else $error("Y-to-X turn from input %0d to output %0d", i, o);
    end
  end

endmodule

`default_nettype wire

// File: hdl/vcr_credit_counter.sv
// **********************************************************
// Downstream credit counters
// Free buffer slots per output and channel
// **********************************************************
`default_nettype none

module vcr_credit_counter (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic [vcr_pkg::NumPorts-1:0]                        fire_i,
  input  logic [vcr_pkg::NumPorts-1:0][vcr_pkg::VcIdWidth-1:0] vc_assign_i,
  input  logic [vcr_pkg::NumPorts-1:0][vcr_pkg::NumVc-1:0]    out_credit_i,
  output logic [vcr_pkg::NumPorts-1:0][vcr_pkg::NumVc-1:0]    has_credit_o
);
  import vcr_pkg::*;

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    for (genvar v = 0; v < NumVc; v++) begin : gen_vc
      logic [CreditWidth-1:0] count_q;
      logic                   dec;
      logic                   inc;

      assign dec = fire_i[o] && (vc_assign_i[o] == VcIdWidth'(v));
      assign inc = out_credit_i[o][v];

      // Send and return in one cycle cancel out
      always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
          count_q <= CreditWidth'(BufDepth);
        end else if (dec && !inc) begin
          count_q <= count_q - 1'b1;
        end else if (inc && !dec) begin
          count_q <= count_q + 1'b1;
        end
      end

      assign has_credit_o[o][v] = (count_q != '0);

      a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec |-> (count_q != '0))
        else $error("credit underflow on output %0d vc %0d", o, v);

      a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (inc && !dec) |-> (count_q != CreditWidth'(BufDepth)))
        else $error("credit overflow on output %0d vc %0d", o, v);
    end
  end

endmodule

`default_nettype wire

// File: hdl/vcr_switch.sv
// **********************************************************
// Router crossbar
// Picks the granted head flit per output, rewrites vc_id
// and last, and registers it onto the output link
// **********************************************************
`default_nettype none

module vcr_switch (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  input  vcr_pkg::flit_t [vcr_pkg::NumPorts-1:0][vcr_pkg::NumVc-1:0] head_flit_i,
  vcr_xbar_ctrl_if.switch                                         ctrl,
  output logic [vcr_pkg::NumPorts-1:0]                            out_valid_o,
  output vcr_pkg::flit_t [vcr_pkg::NumPorts-1:0]                  out_flit_o
);
  import vcr_pkg::*;

  flit_t [NumPorts-1:0] in_sel;
  flit_t [NumPorts-1:0] out_d;

  // Head of the channel being read, per input
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      in_sel[i] = '0;
      for (int v = 0; v < NumVc; v++) begin
        if (ctrl.read_vc_oh[i][v]) begin
          in_sel[i] = head_flit_i[i][v];
        end
      end
    end
  end

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      out_d[o] = '0;
      for (int i = 0; i < NumPorts; i++) begin
        // Turns that XY never takes are not wired
        if (!is_uturn(port_e'(i), port_e'(o)) && !is_y_to_x(port_e'(i), port_e'(o)) &&
            ctrl.inport_oh[o][i]) begin
          out_d[o] = in_sel[i];
        end
      end
      out_d[o].hdr.vc_id = ctrl.vc_assign[o];
      out_d[o].hdr.last  = ctrl.last_sel[o];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_o <= '0;
    end else begin
      out_valid_o <= ctrl.fire;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NumPorts; o++) begin
      if (ctrl.fire[o]) begin
        out_flit_o[o] <= out_d[o];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/vcr_router.sv
// **********************************************************
// Five-port virtual-channel mesh router
// Input buffers, switch allocation, downstream credits and
// the registered crossbar with credit-based links
// **********************************************************
`default_nettype none

module vcr_router #(
  parameter logic [vcr_pkg::CoordWidth-1:0] RouterX = 3'd2,
  parameter logic [vcr_pkg::CoordWidth-1:0] RouterY = 3'd2
) (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic [vcr_pkg::NumPorts-1:0]                     in_valid_i,
  input  vcr_pkg::flit_t [vcr_pkg::NumPorts-1:0]           in_flit_i,
  output logic [vcr_pkg::NumPorts-1:0][vcr_pkg::NumVc-1:0] in_credit_o,
  output logic [vcr_pkg::NumPorts-1:0]                     out_valid_o,
  output vcr_pkg::flit_t [vcr_pkg::NumPorts-1:0]           out_flit_o,
  input  logic [vcr_pkg::NumPorts-1:0][vcr_pkg::NumVc-1:0] out_credit_i
);
  import vcr_pkg::*;

  logic  [NumPorts-1:0][NumVc-1:0] head_valid;
  flit_t [NumPorts-1:0][NumVc-1:0] head_flit;
  hdr_t  [NumPorts-1:0][NumVc-1:0] head_hdr;
  logic  [NumPorts-1:0][NumVc-1:0] has_credit;

  vcr_xbar_ctrl_if xbar_ctrl ();

  for (genvar p = 0; p < NumPorts; p++) begin : gen_in_port
    vcr_input_port u_input_port (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .in_valid_i   (in_valid_i[p]),
      .in_flit_i    (in_flit_i[p]),
      .read_vc_oh_i (xbar_ctrl.read_vc_oh[p]),
      .head_valid_o (head_valid[p]),
      .head_flit_o  (head_flit[p]),
      .in_credit_o  (in_credit_o[p])
    );

    // Allocator only needs the headers
    for (genvar v = 0; v < NumVc; v++) begin : gen_hdr
      assign head_hdr[p][v] = head_flit[p][v].hdr;
    end
  end

  vcr_switch_alloc #(
    .RouterX (RouterX),
    .RouterY (RouterY)
  ) u_switch_alloc (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .head_valid_i (head_valid),
    .head_hdr_i   (head_hdr),
    .has_credit_i (has_credit),
    .ctrl         (xbar_ctrl.alloc)
  );

  vcr_credit_counter u_credit_counter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .fire_i       (xbar_ctrl.fire),
    .vc_assign_i  (xbar_ctrl.vc_assign),
    .out_credit_i (out_credit_i),
    .has_credit_o (has_credit)
  );

  vcr_switch u_switch (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .head_flit_i (head_flit),
    .ctrl        (xbar_ctrl.switch),
    .out_valid_o (out_valid_o),
    .out_flit_o  (out_flit_o)
  );

endmodule

`default_nettype wire

// File: dv/vcr_router_tb.sv
// **********************************************************
// Testbench for the five-port virtual-channel router
// Random packets on every port with upstream credit tracking,
// a downstream credit model, a per-path scoreboard and checks
// **********************************************************
`default_nettype none

module vcr_router_tb;
  import vcr_pkg::*;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod   = 10;
  localparam int RouterX     = 2;
  localparam int RouterY     = 2;
  localparam int PktsPerPort = 60;
  localparam int unsigned Seed = 32'h7025_f017;

  logic                            clk = 1'b0;
  logic                            rst_n = 1'b0;
  logic  [NumPorts-1:0]            in_valid;
  flit_t [NumPorts-1:0]            in_flit;
  logic  [NumPorts-1:0][NumVc-1:0] in_credit;
  logic  [NumPorts-1:0]            out_valid;
  flit_t [NumPorts-1:0]            out_flit;
  logic  [NumPorts-1:0][NumVc-1:0] out_credit;

  // Stimulus and scoreboard state
  flit_t src_q [NumPorts][$];
  flit_t exp_q [NumPorts][NumPorts][$];
  int    ret_q [NumPorts][NumVc][$];
  int    up_credit [NumPorts][NumVc];
  int    accepted [NumPorts][NumVc];
  int    credit_pulses [NumPorts][NumVc];
  int    outstanding [NumPorts][NumVc];
  int    hold_sent [NumVc];
  bit    in_pkt [NumPorts];
  int    pkt_src [NumPorts];
  int    pkt_vc [NumPorts];
  int    total_flits = 0;
  int    sent_count = 0;
  int    recv_count = 0;
  int    err_count = 0;
  int    cycle = 0;
  bit    traffic_on = 1'b0;
  bit    east_hold = 1'b0;
  bit    any_sent = 1'b0;

  vcr_router #(
    .RouterX (3'(RouterX)),
    .RouterY (3'(RouterY))
  ) UUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .in_valid_i   (in_valid),
    .in_flit_i    (in_flit),
    .in_credit_o  (in_credit),
    .out_valid_o  (out_valid),
    .out_flit_o   (out_flit),
    .out_credit_i (out_credit)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  task automatic report_error(input string msg);
    err_count++;
    $display("[ERROR] %0d ns: %s", $time, msg);
  endtask

  task automatic report_test(input string name, input int start_errs);
    if (err_count == start_errs) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, err_count - start_errs);
    end
  endtask

  // XY rule, X is resolved before Y
  function automatic int expected_output(input logic [CoordWidth-1:0] x,
                                         input logic [CoordWidth-1:0] y);
    if (x > RouterX) return int'(East);
    if (x < RouterX) return int'(West);
    if (y > RouterY) return int'(North);
    if (y < RouterY) return int'(South);
    return int'(Local);
  endfunction

  // A neighbour never sends a flit that would turn back or turn from Y to X
  function automatic bit dest_allowed(input int p, input logic [CoordWidth-1:0] x,
                                      input logic [CoordWidth-1:0] y);
    int out;
    out = expected_output(x, y);
    if (out == p && p != int'(Local)) return 1'b0;
    if ((p == int'(North) || p == int'(South)) &&
        (out == int'(East) || out == int'(West))) return 1'b0;
    return 1'b1;
  endfunction

  task automatic build_packets();
    int                    len;
    int                    seq;
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
    logic [VcIdWidth-1:0]  vc;
    flit_t                 f;
    for (int p = 0; p < NumPorts; p++) begin
      seq = 0;
      for (int k = 0; k < PktsPerPort; k++) begin
        len = 1 + int'($urandom % 4);
        vc  = VcIdWidth'($urandom % NumVc);
        do begin
          x = CoordWidth'($urandom % 8);
          y = CoordWidth'($urandom % 8);
        end while (!dest_allowed(p, x, y));
        for (int i = 0; i < len; i++) begin
          f.hdr.dst_x = x;
          f.hdr.dst_y = y;
          f.hdr.vc_id = vc;
          f.hdr.last  = (i == len - 1);
          // Top payload bits name the source port for the scoreboard
          f.payload   = {3'(p), 13'($urandom), 16'(seq)};
          seq++;
          src_q[p].push_back(f);
          total_flits++;
        end
      end
    end
  endtask

  task automatic check_output_flit(input int o, input flit_t f);
    int    src;
    int    vc;
    flit_t e;
    src = int'(f.payload[31:29]);
    vc  = int'(f.hdr.vc_id);
    recv_count++;
    assert (expected_output(f.hdr.dst_x, f.hdr.dst_y) == o)
      else report_error($sformatf("flit on output %0d belongs elsewhere", o));
    assert (src < NumPorts) else report_error($sformatf("bad source %0d on output %0d", src, o));
    if (src < NumPorts) begin
      assert (exp_q[src][o].size() != 0)
        else report_error($sformatf("unexpected flit from %0d on output %0d", src, o));
      if (exp_q[src][o].size() != 0) begin
        e = exp_q[src][o].pop_front();
        assert (f.payload == e.payload && f.hdr.dst_x == e.hdr.dst_x &&
                f.hdr.dst_y == e.hdr.dst_y && f.hdr.last == e.hdr.last)
          else report_error($sformatf("output %0d got %h, expected %h", o, f, e));
      end
    end
    // Packet stays whole and on one downstream channel
    if (in_pkt[o]) begin
      assert (src == pkt_src[o] && vc == pkt_vc[o])
        else report_error($sformatf("packet on output %0d interleaved", o));
    end
    in_pkt[o]  = !f.hdr.last;
    pkt_src[o] = src;
    pkt_vc[o]  = vc;
    outstanding[o][vc]++;
    assert (outstanding[o][vc] <= BufDepth)
      else report_error($sformatf("output %0d vc %0d exceeds downstream space", o, vc));
    if (east_hold && o == int'(East)) begin
      hold_sent[vc]++;
      assert (hold_sent[vc] <= BufDepth)
        else report_error($sformatf("East vc %0d sent past its credits", vc));
    end
    ret_q[o][vc].push_back(cycle + 1 + int'($urandom % 6));
  endtask

  task automatic final_checks();
    for (int i = 0; i < NumPorts; i++) begin
      for (int o = 0; o < NumPorts; o++) begin
        assert (exp_q[i][o].size() == 0)
          else report_error($sformatf("%0d flits from %0d to %0d never arrived",
                                      exp_q[i][o].size(), i, o));
      end
      for (int v = 0; v < NumVc; v++) begin
        assert (credit_pulses[i][v] == accepted[i][v])
          else report_error($sformatf("port %0d vc %0d credits %0d, accepted %0d",
                                      i, v, credit_pulses[i][v], accepted[i][v]));
      end
    end
    assert (sent_count == total_flits && recv_count == sent_count)
      else report_error($sformatf("sent %0d, received %0d, generated %0d",
                                  sent_count, recv_count, total_flits));
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      cycle++;
      for (int p = 0; p < NumPorts; p++) begin
        for (int v = 0; v < NumVc; v++) begin
          if (in_credit[p][v]) begin
            credit_pulses[p][v]++;
            up_credit[p][v]++;
            assert (up_credit[p][v] <= BufDepth)
              else report_error($sformatf("extra credit on port %0d vc %0d", p, v));
          end
        end
      end
      for (int o = 0; o < NumPorts; o++) begin
        if (out_valid[o]) begin
          check_output_flit(o, out_flit[o]);
        end
      end
    end
  end

  // Upstream senders and downstream credit return
  always @(posedge clk) begin
    flit_t f;
    int    v;
    int    dst_out;
    int    idx;
    bit    found;
    #1;
    for (int p = 0; p < NumPorts; p++) begin
      in_valid[p] = 1'b0;
      if (traffic_on && src_q[p].size() != 0 && ($urandom % 4) != 0) begin
        f       = src_q[p][0];
        v       = int'(f.hdr.vc_id);
        dst_out = expected_output(f.hdr.dst_x, f.hdr.dst_y);
        // A packet waits until an older one to the same output on the
        // other channel has left, so it cannot overtake it
        if (up_credit[p][v] > 0 &&
            (exp_q[p][dst_out].size() == 0 ||
             exp_q[p][dst_out][$].hdr.vc_id == f.hdr.vc_id)) begin
          in_valid[p] = 1'b1;
          in_flit[p]  = f;
          up_credit[p][v]--;
          accepted[p][v]++;
          exp_q[p][dst_out].push_back(f);
          void'(src_q[p].pop_front());
          sent_count++;
          any_sent = 1'b1;
        end
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      for (int c = 0; c < NumVc; c++) begin
        out_credit[o][c] = 1'b0;
        found = 1'b0;
        idx   = 0;
        if (!(east_hold && o == int'(East))) begin
          for (int k = 0; k < ret_q[o][c].size(); k++) begin
            if (!found && ret_q[o][c][k] <= cycle) begin
              found = 1'b1;
              idx   = k;
            end
          end
        end
        if (found) begin
          ret_q[o][c].delete(idx);
          out_credit[o][c] = 1'b1;
          outstanding[o][c]--;
        end
      end
    end
  end

  a_quiet_after_reset : assert property (@(posedge clk) disable iff (!rst_n)
    !any_sent |-> (out_valid == '0) && (in_credit == '0))
    else report_error("output activity before the first flit");

  initial begin : watchdog
    wait (total_flits != 0);
    #(total_flits * 20 * 10 * ClkPeriod);
    $display("Timeout: traffic did not drain within %0d cycles", total_flits * 200);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int test_start;
    in_valid   = '0;
    in_flit    = '0;
    out_credit = '0;
    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVc; v++) begin
        up_credit[p][v] = BufDepth;
      end
    end
    void'($urandom(Seed));
    build_packets();
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;

    test_start = err_count;
    repeat (10) @(posedge clk);
    report_test("reset_idle", test_start);

    test_start = err_count;
    traffic_on = 1'b1;
    repeat (60) @(posedge clk);
    report_test("random_traffic", test_start);

    // East downstream stops returning credits for a while
    test_start = err_count;
    hold_sent  = '{default: 0};
    east_hold  = 1'b1;
    repeat (50) @(posedge clk);
    east_hold  = 1'b0;
    report_test("east_backpressure", test_start);

    test_start = err_count;
    while (recv_count < total_flits) @(posedge clk);
    repeat (20) @(posedge clk);
    final_checks();
    report_test("drain", test_start);

    $display("summary: 4 tests, %0d flits sent, %0d flits received, %0d errors",
             sent_count, recv_count, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vcr_router.f
hdl/vcr_pkg.sv
hdl/vcr_xbar_ctrl_if.sv
hdl/vcr_input_port.sv
hdl/vcr_switch_alloc.sv
hdl/vcr_credit_counter.sv
hdl/vcr_switch.sv
hdl/vcr_router.sv
dv/vcr_router_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the vcr_router testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module vcr_router_tb \
  -f vcr_router.f \
  -o vcr_router_sim
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/vcr_router_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  echo "Result: failed"
  exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
  echo "Result: no pass line in $LOG"
  exit 1
fi
echo "Result: passed"
exit 0
